/* Makefile */
TOP = tb_exec_core
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module exec_core

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG) || (echo "no result in log"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* hdl/alu_unit.sv */
module alu_unit (
    exec_op_if.unit                   i_op,
    output logic [exec_pkg::XLEN-1:0] o_result
);
    import exec_pkg::*;

    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN:0]   difference;
    logic [4:0]      shamt;
    logic            less_signed;
    logic            less_unsigned;

    assign operand_a = i_op.rs1_val;
    assign operand_b = i_op.use_imm ? i_op.imm : i_op.rs2_val;

    // One subtractor serves SUB, SLT and SLTU
    assign difference    = {1'b0, operand_a} - {1'b0, operand_b};
    assign less_unsigned = difference[XLEN];
    // Signs differ means the negative operand is the smaller one
    assign less_signed   = (operand_a[XLEN-1] != operand_b[XLEN-1]) ?
                           operand_a[XLEN-1] : difference[XLEN-1];

    assign shamt = operand_b[4:0];

    always_comb begin
        unique case (i_op.alu_op)
            ALU_SUB:  o_result = difference[XLEN-1:0];
            ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, less_signed};
            ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, less_unsigned};
            ALU_XOR:  o_result = operand_a ^ operand_b;
            ALU_OR:   o_result = operand_a | operand_b;
            ALU_AND:  o_result = operand_a & operand_b;
            ALU_SLL:  o_result = operand_a << shamt;
            ALU_SRL:  o_result = operand_a >> shamt;
            ALU_SRA:  o_result = $signed(operand_a) >>> shamt;
            default:  o_result = operand_a + operand_b;
        endcase
    end

endmodule

/* hdl/branch_unit.sv */
module branch_unit (
    exec_op_if.unit                   i_op,
    output logic                      o_taken,
    output logic [exec_pkg::XLEN-1:0] o_next_pc
);
    import exec_pkg::*;

    logic equal;
    logic less_signed;
    logic less_unsigned;
    logic cond_true;

    assign equal         = (i_op.rs1_val == i_op.rs2_val);
    assign less_signed   = ($signed(i_op.rs1_val) < $signed(i_op.rs2_val));
    assign less_unsigned = (i_op.rs1_val < i_op.rs2_val);

    always_comb begin
        unique case (i_op.cond)
            3'b000:  cond_true = equal;          // BEQ
            3'b001:  cond_true = !equal;         // BNE
            3'b100:  cond_true = less_signed;    // BLT
            3'b101:  cond_true = !less_signed;   // BGE
            3'b110:  cond_true = less_unsigned;  // BLTU
            3'b111:  cond_true = !less_unsigned; // BGEU
            default: cond_true = 1'b0;
        endcase
    end

    assign o_taken   = i_op.is_branch && cond_true;
    assign o_next_pc = o_taken ? (i_op.pc + i_op.imm) : (i_op.pc + XLEN'(4));

endmodule

/* hdl/commit_unit.sv */
module commit_unit (
    input  logic                            clk,
    input  logic                            resetn,
    exec_op_if.unit                         i_op,
    input  logic [exec_pkg::XLEN-1:0]       i_alu_result,
    input  logic [exec_pkg::XLEN-1:0]       i_next_pc,
    // Register write port, also the bypass source
    output logic                            o_wr_en,
    output logic [exec_pkg::REG_ADDR_W-1:0] o_wr_rd,
    output logic [exec_pkg::XLEN-1:0]       o_wr_data,
    output logic                            o_wb_valid,
    output logic [exec_pkg::XLEN-1:0]       o_wb_pc,
    output logic [exec_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic [exec_pkg::XLEN-1:0]       o_wb_data,
    output logic                            o_redirect_valid,
    output logic [exec_pkg::XLEN-1:0]       o_redirect_pc
);
    import exec_pkg::*;

    logic [XLEN-1:0] expected_pc;
    logic            mispredict;
    logic            commit;
    logic            squash;
    logic [XLEN-1:0] wb_data;

    assign commit = i_op.valid && (i_op.pc == expected_pc);
    // Only the first wrong-path op asks for a redirect
    assign squash = i_op.valid && (i_op.pc != expected_pc) && !mispredict;

    assign o_wr_en   = commit && i_op.writes_rd && (i_op.rd != '0);
    assign o_wr_rd   = i_op.rd;
    assign o_wr_data = i_alu_result;

    always_comb begin
        if (i_op.is_branch) begin
            wb_data = i_next_pc;
        end else if (i_op.writes_rd) begin
            wb_data = i_alu_result;
        end else begin
            wb_data = '0;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            expected_pc      <= RESET_PC;
            mispredict       <= 1'b0;
            o_wb_valid       <= 1'b0;
            o_redirect_valid <= 1'b0;
        end else begin
            o_wb_valid       <= commit;
            o_redirect_valid <= squash;
            if (commit) begin
                expected_pc <= i_next_pc;
                mispredict  <= 1'b0;
            end else if (squash) begin
                mispredict <= 1'b1;
            end
        end
    end

    // Sampled only while the matching valid is high
    always_ff @(posedge clk) begin
        o_wb_pc       <= i_op.pc;
        o_wb_rd       <= o_wr_en ? i_op.rd : '0;
        o_wb_data     <= wb_data;
        o_redirect_pc <= expected_pc;
    end

endmodule

/* hdl/exec_core.sv */
module exec_core (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            i_issue_valid,
    input  logic [31:0]                     i_issue_instr,
    input  logic [exec_pkg::XLEN-1:0]       i_issue_pc,
    output logic                            o_wb_valid,
    output logic [exec_pkg::XLEN-1:0]       o_wb_pc,
    output logic [exec_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic [exec_pkg::XLEN-1:0]       o_wb_data,
    output logic                            o_redirect_valid,
    output logic [exec_pkg::XLEN-1:0]       o_redirect_pc
);
    import exec_pkg::*;

    instr_u                issue_instr;
    logic [REG_ADDR_W-1:0] dec_rs1;
    logic [REG_ADDR_W-1:0] dec_rs2;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic [XLEN-1:0]       dec_imm;
    logic                  dec_use_imm;
    logic                  dec_is_branch;
    logic                  dec_writes_rd;
    logic [ALU_OP_W-1:0]   dec_alu_op;
    logic [2:0]            dec_cond;
    logic [XLEN-1:0]       rf_rs1_data;
    logic [XLEN-1:0]       rf_rs2_data;
    logic                  wr_en;
    logic [REG_ADDR_W-1:0] wr_rd;
    logic [XLEN-1:0]       wr_data;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       br_next_pc;

    exec_op_if op_bus ();

    assign issue_instr = i_issue_instr;

    instr_decoder u_decoder (
        .i_instr     (issue_instr),
        .o_rs1       (dec_rs1),
        .o_rs2       (dec_rs2),
        .o_rd        (dec_rd),
        .o_imm       (dec_imm),
        .o_use_imm   (dec_use_imm),
        .o_is_branch (dec_is_branch),
        .o_writes_rd (dec_writes_rd),
        .o_alu_op    (dec_alu_op),
        .o_cond      (dec_cond)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .resetn     (resetn),
        .i_rs1_sel  (dec_rs1),
        .i_rs2_sel  (dec_rs2),
        .i_wr_rd    (wr_rd),
        .i_wr_en    (wr_en),
        .i_wr_data  (wr_data),
        .o_rs1_data (rf_rs1_data),
        .o_rs2_data (rf_rs2_data)
    );

    operand_stage u_operand_stage (
        .clk           (clk),
        .resetn        (resetn),
        .i_issue_valid (i_issue_valid),
        .i_pc          (i_issue_pc),
        .i_rs1         (dec_rs1),
        .i_rs2         (dec_rs2),
        .i_rd          (dec_rd),
        .i_imm         (dec_imm),
        .i_use_imm     (dec_use_imm),
        .i_is_branch   (dec_is_branch),
        .i_writes_rd   (dec_writes_rd),
        .i_alu_op      (dec_alu_op),
        .i_cond        (dec_cond),
        .i_rs1_data    (rf_rs1_data),
        .i_rs2_data    (rf_rs2_data),
        .i_byp_en      (wr_en),
        .i_byp_rd      (wr_rd),
        .i_byp_data    (wr_data),
        .o_op          (op_bus.stage)
    );

    alu_unit u_alu (
        .i_op     (op_bus.unit),
        .o_result (alu_result)
    );

    // Taken flag is folded into the next PC already
    branch_unit u_branch (
        .i_op      (op_bus.unit),
        .o_taken   (),
        .o_next_pc (br_next_pc)
    );

    commit_unit u_commit (
        .clk              (clk),
        .resetn           (resetn),
        .i_op             (op_bus.unit),
        .i_alu_result     (alu_result),
        .i_next_pc        (br_next_pc),
        .o_wr_en          (wr_en),
        .o_wr_rd          (wr_rd),
        .o_wr_data        (wr_data),
        .o_wb_valid       (o_wb_valid),
        .o_wb_pc          (o_wb_pc),
        .o_wb_rd          (o_wb_rd),
        .o_wb_data        (o_wb_data),
        .o_redirect_valid (o_redirect_valid),
        .o_redirect_pc    (o_redirect_pc)
    );

endmodule

/* hdl/exec_op_if.sv */
interface exec_op_if;
    import exec_pkg::*;

    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
    logic [XLEN-1:0]       imm;
    logic                  use_imm;
    logic [ALU_OP_W-1:0]   alu_op;
    // Branch funct3
    logic [2:0]            cond;
    logic                  is_branch;
    logic                  writes_rd;

    // Driven by the issue register
    modport stage (
        output valid, pc, rd, rs1_val, rs2_val, imm, use_imm, alu_op, cond,
        is_branch, writes_rd
    );

    // Read by ALU, branch and commit logic
    modport unit (
        input valid, pc, rd, rs1_val, rs2_val, imm, use_imm, alu_op, cond,
        is_branch, writes_rd
    );

endinterface

/* hdl/exec_pkg.sv */
package exec_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 4;

    // ALU operation codes
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd9;

    // Major opcodes handled by the back end
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

    // One instruction word seen as R, I or B format
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic                  imm12;
            logic [5:0]            imm10_5;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [3:0]            imm4_1;
            logic                  imm11;
            logic [6:0]            opcode;
        } b;
    } instr_u;

endpackage

/* hdl/instr_decoder.sv */
module instr_decoder (
    input  exec_pkg::instr_u                   i_instr,
    output logic [exec_pkg::REG_ADDR_W-1:0]    o_rs1,
    output logic [exec_pkg::REG_ADDR_W-1:0]    o_rs2,
    output logic [exec_pkg::REG_ADDR_W-1:0]    o_rd,
    output logic [exec_pkg::XLEN-1:0]          o_imm,
    output logic                               o_use_imm,
    output logic                               o_is_branch,
    output logic                               o_writes_rd,
    output logic [exec_pkg::ALU_OP_W-1:0]      o_alu_op,
    output logic [2:0]                         o_cond
);
    import exec_pkg::*;

    logic is_op;

    assign is_op = (i_instr.r.opcode == OPC_OP);

    // Register selects sit at the same bits in every format
    assign o_rs1 = i_instr.r.rs1;
    assign o_rs2 = i_instr.r.rs2;
    assign o_rd  = i_instr.r.rd;

    always_comb begin
        o_imm       = '0;
        o_use_imm   = 1'b0;
        o_is_branch = 1'b0;
        o_writes_rd = 1'b0;
        o_cond      = 3'b000;

        unique case (i_instr.r.opcode)
            OPC_OP: begin
                o_writes_rd = 1'b1;
            end
            OPC_OP_IMM: begin
                o_writes_rd = 1'b1;
                o_use_imm   = 1'b1;
                o_imm       = {{(XLEN-12){i_instr.i.imm12[11]}}, i_instr.i.imm12};
            end
            OPC_BRANCH: begin
                o_is_branch = 1'b1;
                o_cond      = i_instr.b.funct3;
                o_imm       = {{(XLEN-13){i_instr.b.imm12}}, i_instr.b.imm12,
                               i_instr.b.imm11, i_instr.b.imm10_5, i_instr.b.imm4_1, 1'b0};
            end
            default: begin
                // Anything else retires as a no-op
                o_writes_rd = 1'b0;
            end
        endcase
    end

    // Bit 30 picks SUB in R form only and SRA in both forms
    always_comb begin
        unique case (i_instr.r.funct3)
            3'b000:  o_alu_op = (is_op && i_instr.r.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  o_alu_op = ALU_SLL;
            3'b010:  o_alu_op = ALU_SLT;
            3'b011:  o_alu_op = ALU_SLTU;
            3'b100:  o_alu_op = ALU_XOR;
            3'b101:  o_alu_op = i_instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  o_alu_op = ALU_OR;
            default: o_alu_op = ALU_AND;
        endcase
    end

endmodule

/* hdl/operand_stage.sv */
module operand_stage (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            i_issue_valid,
    input  logic [exec_pkg::XLEN-1:0]       i_pc,
    // Decoded fields
    input  logic [exec_pkg::REG_ADDR_W-1:0] i_rs1,
    input  logic [exec_pkg::REG_ADDR_W-1:0] i_rs2,
    input  logic [exec_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic [exec_pkg::XLEN-1:0]       i_imm,
    input  logic                            i_use_imm,
    input  logic                            i_is_branch,
    input  logic                            i_writes_rd,
    input  logic [exec_pkg::ALU_OP_W-1:0]   i_alu_op,
    input  logic [2:0]                      i_cond,
    // Register file read data
    input  logic [exec_pkg::XLEN-1:0]       i_rs1_data,
    input  logic [exec_pkg::XLEN-1:0]       i_rs2_data,
    // Value being committed this cycle
    input  logic                            i_byp_en,
    input  logic [exec_pkg::REG_ADDR_W-1:0] i_byp_rd,
    input  logic [exec_pkg::XLEN-1:0]       i_byp_data,
    exec_op_if.stage                        o_op
);
    import exec_pkg::*;

    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;

    // Write enable only rises for rd != 0, so x0 never gets bypassed
    assign rs1_val = (i_byp_en && i_byp_rd == i_rs1) ? i_byp_data : i_rs1_data;
    assign rs2_val = (i_byp_en && i_byp_rd == i_rs2) ? i_byp_data : i_rs2_data;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_op.valid <= 1'b0;
        end else begin
            o_op.valid <= i_issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_issue_valid) begin
            o_op.pc        <= i_pc;
            o_op.rd        <= i_rd;
            o_op.rs1_val   <= rs1_val;
            o_op.rs2_val   <= rs2_val;
            o_op.imm       <= i_imm;
            o_op.use_imm   <= i_use_imm;
            o_op.alu_op    <= i_alu_op;
            o_op.cond      <= i_cond;
            o_op.is_branch <= i_is_branch;
            o_op.writes_rd <= i_writes_rd;
        end
    end

endmodule

/* hdl/reg_file.sv */
module reg_file (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic [exec_pkg::REG_ADDR_W-1:0] i_rs1_sel,
    input  logic [exec_pkg::REG_ADDR_W-1:0] i_rs2_sel,
    input  logic [exec_pkg::REG_ADDR_W-1:0] i_wr_rd,
    input  logic                            i_wr_en,
    input  logic [exec_pkg::XLEN-1:0]       i_wr_data,
    output logic [exec_pkg::XLEN-1:0]       o_rs1_data,
    output logic [exec_pkg::XLEN-1:0]       o_rs2_data
);
    import exec_pkg::*;

    // x1..x31, x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int idx = 1; idx < 32; idx++) begin
                regs[idx] <= '0;
            end
        end else if (i_wr_en && i_wr_rd != '0) begin
            regs[i_wr_rd] <= i_wr_data;
        end
    end

    assign o_rs1_data = (i_rs1_sel == '0) ? '0 : regs[i_rs1_sel];
    assign o_rs2_data = (i_rs2_sel == '0) ? '0 : regs[i_rs2_sel];

endmodule

/* list.f */
+incdir+include
hdl/exec_pkg.sv
hdl/exec_op_if.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/operand_stage.sv
hdl/alu_unit.sv
hdl/branch_unit.sv
hdl/commit_unit.sv
hdl/exec_core.sv
testbench/tb_exec_core.sv

/* include/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Outcome of one issued instruction
localparam int EV_DROP  = 0;
localparam int EV_WB    = 1;
localparam int EV_REDIR = 2;

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// Instruction encoders
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

// Matching PC commits, the first miss redirects and later misses drop
function automatic int commit_action(input logic [31:0] pc, input logic [31:0] exp_pc,
                                     input logic flag);
    if (pc == exp_pc) begin
        return EV_WB;
    end else if (!flag) begin
        return EV_REDIR;
    end else begin
        return EV_DROP;
    end
endfunction

// Committed result of one instruction
// rd stays 0 when nothing is written
function automatic void ref_exec(input logic [31:0] instr, input logic [31:0] pc,
                                 input logic [31:0] op_a, input logic [31:0] rs2_val,
                                 output logic [4:0] rd, output logic [31:0] data,
                                 output logic [31:0] next_pc);
    logic [6:0]  opcode;
    logic [2:0]  f3;
    logic [31:0] op_b;
    logic [31:0] imm_b;
    logic        taken;
    opcode  = instr[6:0];
    f3      = instr[14:12];
    imm_b   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    op_b    = (opcode == OPC_OP_IMM) ? {{20{instr[31]}}, instr[31:20]} : rs2_val;
    rd      = 5'd0;
    data    = 32'd0;
    next_pc = pc + 32'd4;
    taken   = 1'b0;
    if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
        rd = instr[11:7];
        case (f3)
            3'b000:  data = (opcode == OPC_OP && instr[30]) ? op_a - op_b : op_a + op_b;
            3'b001:  data = op_a << op_b[4:0];
            3'b010:  data = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            3'b011:  data = (op_a < op_b) ? 32'd1 : 32'd0;
            3'b100:  data = op_a ^ op_b;
            3'b101: begin
                if (instr[30]) begin
                    data = $signed(op_a) >>> op_b[4:0];
                end else begin
                    data = op_a >> op_b[4:0];
                end
            end
            3'b110:  data = op_a | op_b;
            default: data = op_a & op_b;
        endcase
    end else if (opcode == OPC_BRANCH) begin
        case (f3)
            3'b000:  taken = (op_a == rs2_val);
            3'b001:  taken = (op_a != rs2_val);
            3'b100:  taken = ($signed(op_a) < $signed(rs2_val));
            3'b101:  taken = ($signed(op_a) >= $signed(rs2_val));
            3'b110:  taken = (op_a < rs2_val);
            3'b111:  taken = (op_a >= rs2_val);
            default: taken = 1'b0;
        endcase
        if (taken) begin
            next_pc = pc + imm_b;
        end
        data = next_pc;
    end
endfunction

`endif

/* testbench/tb_exec_core.sv */
module tb_exec_core;
    import exec_pkg::*;

    `include "tb_ref_model.svh"

    localparam int DRAIN_LIMIT = 10;

    typedef struct packed {
        int          kind;
        int          due;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
    } ev_t;

    logic        clk = 1'b0;
    logic        resetn;
    logic        issue_valid;
    logic [31:0] issue_instr;
    logic [31:0] issue_pc;
    logic        wb_valid;
    logic [31:0] wb_pc;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    // Reference state, advanced in issue order
    logic [31:0] model_regs [0:31];
    logic [31:0] model_pc;
    logic        model_flag;
    logic [31:0] fetch_pc;
    logic [31:0] lcg_state;
    ev_t         event_q[$];
    int          edge_count;
    int          checks;
    int          errors;
    int          check_start;
    int          error_start;
    int          tests_run;
    bit          aborted;
    string       cur_test;

    exec_core u_dut (
        .clk              (clk),
        .resetn           (resetn),
        .i_issue_valid    (issue_valid),
        .i_issue_instr    (issue_instr),
        .i_issue_pc       (issue_pc),
        .o_wb_valid       (wb_valid),
        .o_wb_pc          (wb_pc),
        .o_wb_rd          (wb_rd),
        .o_wb_data        (wb_data),
        .o_redirect_valid (redirect_valid),
        .o_redirect_pc    (redirect_pc)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        edge_count++;
    end

    function automatic logic [31:0] rand_bits(input int n);
        lcg_state = lcg_next(lcg_state);
        return lcg_state >> (32 - n);
    endfunction

    // Random R or I form ALU op on x0..x7
    function automatic logic [31:0] gen_alu();
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [11:0] imm;
        logic        alt;
        f3  = 3'(rand_bits(3));
        rs1 = 5'(rand_bits(3));
        rs2 = 5'(rand_bits(3));
        rd  = 5'(rand_bits(3));
        imm = 12'(rand_bits(12));
        alt = 1'(rand_bits(1));
        if (f3 == 3'b001 || f3 == 3'b101) begin
            imm = {1'b0, alt, 5'd0, imm[4:0]};
        end
        if (rand_bits(1) == 32'd1) begin
            return enc_r((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'd0,
                         rs2, rs1, f3, rd);
        end
        return enc_i(imm, rs1, f3, rd);
    endfunction

    function automatic logic [31:0] gen_branch();
        logic [2:0] f3;
        logic [4:0] r;
        f3 = 3'(rand_bits(3));
        r  = 5'(rand_bits(5));
        // funct3 2 and 3 are not branches
        if (f3 == 3'd2 || f3 == 3'd3) begin
            f3 = f3 + 3'd2;
        end
        return enc_b({{6{r[4]}}, r, 2'b00}, 5'(rand_bits(3)), 5'(rand_bits(3)), f3);
    endfunction

    // LUI sits outside the kept formats
    function automatic logic [31:0] gen_noop();
        return {20'(rand_bits(20)), 5'(rand_bits(3)), 7'b0110111};
    endfunction

    task automatic predict(input logic [31:0] instr, input logic [31:0] pc);
        ev_t         ev;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] next_pc;
        ev.kind = commit_action(pc, model_pc, model_flag);
        ev.due  = edge_count + 2;
        ev.pc   = pc;
        ev.rd   = 5'd0;
        ev.data = 32'd0;
        if (ev.kind == EV_WB) begin
            ref_exec(instr, pc, model_regs[instr[19:15]], model_regs[instr[24:20]],
                     rd, data, next_pc);
            ev.rd   = rd;
            ev.data = data;
            if (rd != 5'd0) begin
                model_regs[rd] = data;
            end
            model_pc   = next_pc;
            model_flag = 1'b0;
        end else if (ev.kind == EV_REDIR) begin
            ev.pc      = model_pc;
            model_flag = 1'b1;
        end
        event_q.push_back(ev);
    endtask

    task automatic follow_redirect();
        if (redirect_valid === 1'b1) begin
            fetch_pc = redirect_pc;
        end
    endtask

    task automatic issue(input logic [31:0] instr, input logic wrong);
        @(negedge clk);
        follow_redirect();
        issue_valid = 1'b1;
        issue_instr = instr;
        issue_pc    = fetch_pc;
        // A wrong PC while already off path would never be redirected
        if (wrong && !model_flag) begin
            issue_pc = fetch_pc ^ 32'h0000_0100;
        end
        predict(instr, issue_pc);
        fetch_pc = issue_pc + 32'd4;
    endtask

    task automatic idle();
        @(negedge clk);
        follow_redirect();
        issue_valid = 1'b0;
        issue_instr = 32'd0;
    endtask

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: %s expected %h actual %h",
                     cur_test, field, expected, actual);
            errors++;
        end
    endtask

    task automatic check_event(input ev_t ev);
        if (ev.kind == EV_WB) begin
            if (wb_valid !== 1'b1 || redirect_valid !== 1'b0) begin
                $display("ERROR in %s: no writeback for pc %h at edge %0d",
                         cur_test, ev.pc, edge_count);
                errors++;
            end else begin
                check_value("wb_pc", ev.pc, wb_pc);
                check_value("wb_rd", {27'd0, ev.rd}, {27'd0, wb_rd});
                check_value("wb_data", ev.data, wb_data);
            end
        end else if (ev.kind == EV_REDIR) begin
            if (redirect_valid !== 1'b1 || wb_valid !== 1'b0) begin
                $display("ERROR in %s: no redirect at edge %0d", cur_test, edge_count);
                errors++;
            end else begin
                check_value("redirect_pc", ev.pc, redirect_pc);
            end
        end else if (wb_valid !== 1'b0 || redirect_valid !== 1'b0) begin
            $display("ERROR in %s: wrong-path instruction at pc %h was not dropped",
                     cur_test, ev.pc);
            errors++;
        end
    endtask

    // Outputs are sampled half a cycle after the edge that registers them
    always @(negedge clk) begin
        ev_t ev;
        checks++;
        if (event_q.size() != 0 && event_q[0].due == edge_count) begin
            ev = event_q.pop_front();
            check_event(ev);
        end else if (wb_valid !== 1'b0 || redirect_valid !== 1'b0) begin
            $display("ERROR in %s: output pulse at edge %0d with nothing due",
                     cur_test, edge_count);
            errors++;
        end
    end

    task automatic start_test(input string name);
        cur_test    = name;
        check_start = checks;
        error_start = errors;
    endtask

    task automatic end_test();
        int waited;
        waited = 0;
        while (event_q.size() != 0 && waited < DRAIN_LIMIT) begin
            idle();
            waited++;
        end
        tests_run++;
        if (event_q.size() != 0) begin
            $display("ERROR in %s: %0d outputs never arrived", cur_test, event_q.size());
            errors++;
            aborted = 1'b1;
        end else begin
            $display("test %s: %s, %0d checks, %0d errors", cur_test,
                     (errors == error_start) ? "PASS" : "FAIL",
                     checks - check_start, errors - error_start);
        end
    endtask

    task automatic test_reset();
        start_test("reset_state");
        repeat (8) @(negedge clk);
        resetn = 1'b1;
        repeat (3) idle();
        end_test();
    endtask

    task automatic test_alu();
        start_test("alu_ops");
        for (int r = 1; r < 8; r++) begin
            issue(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'(r)), 1'b0);
        end
        for (int n = 0; n < 60; n++) begin
            issue(gen_alu(), 1'b0);
            if (rand_bits(2) == 32'd0) begin
                idle();
            end
        end
        end_test();
    endtask

    task automatic test_x0();
        start_test("x0_writes");
        // addi x0, x1, 0x123 then add x2, x0, x0
        issue(enc_i(12'h123, 5'd1, 3'b000, 5'd0), 1'b0);
        issue(enc_r(7'd0, 5'd0, 5'd0, 3'b000, 5'd2), 1'b0);
        issue(enc_r(7'd0, 5'd2, 5'd3, 3'b110, 5'd0), 1'b0);
        idle();
        issue(enc_i(12'h7ff, 5'd0, 3'b100, 5'd4), 1'b0);
        issue(enc_r(7'b0100000, 5'd0, 5'd4, 3'b000, 5'd5), 1'b0);
        end_test();
    endtask

    task automatic test_branch();
        start_test("branches");
        for (int n = 0; n < 30; n++) begin
            issue(gen_branch(), 1'b0);
            issue(gen_alu(), 1'b0);
            if (rand_bits(2) == 32'd0) begin
                idle();
            end
        end
        end_test();
    endtask

    task automatic test_mispredict();
        start_test("mispredict");
        for (int n = 0; n < 20; n++) begin
            issue(gen_alu(), 1'b0);
            issue(gen_alu(), 1'b1);
            repeat (3) issue(gen_alu(), 1'b0);
            if (rand_bits(1) == 32'd0) begin
                idle();
            end
        end
        end_test();
    endtask

    task automatic test_random();
        logic [31:0] sel;
        start_test("random_mix");
        for (int n = 0; n < 200; n++) begin
            sel = rand_bits(4);
            if (sel < 9) begin
                issue(gen_alu(), 1'b0);
            end else if (sel < 13) begin
                issue(gen_branch(), 1'b0);
            end else if (sel == 13) begin
                issue(gen_noop(), 1'b0);
            end else begin
                issue(gen_alu(), 1'b1);
            end
            if (rand_bits(3) == 32'd0) begin
                idle();
            end
        end
        end_test();
    endtask

    initial begin
        resetn      = 1'b0;
        issue_valid = 1'b0;
        issue_instr = 32'd0;
        issue_pc    = 32'd0;
        lcg_state   = 32'h8d07ab07;
        model_pc    = RESET_PC;
        model_flag  = 1'b0;
        fetch_pc    = RESET_PC;
        edge_count  = 0;
        checks      = 0;
        errors      = 0;
        tests_run   = 0;
        aborted     = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'd0;
        end
        for (int t = 0; t < 6 && !aborted; t++) begin
            case (t)
                0:       test_reset();
                1:       test_alu();
                2:       test_x0();
                3:       test_branch();
                4:       test_mispredict();
                default: test_random();
            endcase
        end
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0 && !aborted) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
